// ==== dv/tb_mem_subsys.sv ====
// Memory subsystem testbench
// Table-driven bus master, external slave responder and reference memory

`timescale 1ns/1ps

module tb_mem_subsys;

  localparam int RESET_CYCLES   = 16;
  localparam int CYCLES_PER_ROW = 50;
  localparam int MAX_ROWS       = 32;

  logic                                clk_i = 1'b0;
  logic                                rst_n_i, ext_active_i;
  logic                                aw_valid_i, w_valid_i, b_ready_i, ar_valid_i, r_ready_i;
  logic                                aw_ready_o, w_ready_o, b_valid_o, ar_ready_o, r_valid_o;
  logic [bus_pkg::ID_W-1:0]            aw_id_i, ar_id_i, b_id_o, r_id_o;
  logic [bus_pkg::ADDR_W-1:0]          aw_addr_i, ar_addr_i;
  logic [bus_pkg::DATA_W-1:0]          w_data_i, r_data_o;
  logic [bus_pkg::STRB_W-1:0]          w_strb_i;
  logic [bus_pkg::RESP_W-1:0]          b_resp_o, r_resp_o;
  logic                                ext_aw_valid_o, ext_w_valid_o, ext_b_ready_o;
  logic                                ext_ar_valid_o, ext_r_ready_o;
  logic [bus_pkg::ID_W-1:0]            ext_aw_id_o, ext_ar_id_o, ext_b_id_i, ext_r_id_i;
  logic [bus_pkg::ADDR_W-1:0]          ext_aw_addr_o, ext_ar_addr_o;
  logic [bus_pkg::DATA_W-1:0]          ext_w_data_o, ext_r_data_i;
  logic [bus_pkg::STRB_W-1:0]          ext_w_strb_o;
  logic                                ext_aw_ready_i, ext_w_ready_i, ext_b_valid_i;
  logic                                ext_ar_ready_i, ext_r_valid_i;
  logic [bus_pkg::RESP_W-1:0]          ext_b_resp_i, ext_r_resp_i;
  logic                                exit_valid_o;
  logic [mem_map_pkg::EXIT_CODE_W-1:0] exit_code_o;

  // One bus transaction and what it should return
  typedef struct {
    bit                                  is_wr;
    bit                                  ext;
    logic [bus_pkg::ID_W-1:0]            id;
    logic [bus_pkg::ADDR_W-1:0]          addr;
    logic [bus_pkg::DATA_W-1:0]          data;
    logic [bus_pkg::STRB_W-1:0]          strb;
    int                                  stall;
    logic [bus_pkg::RESP_W-1:0]          exp_resp;
    logic [bus_pkg::DATA_W-1:0]          exp_data;
    bit                                  exp_exit;
    logic [mem_map_pkg::EXIT_CODE_W-1:0] exp_code;
  } row_t;

  row_t                       rows [MAX_ROWS];
  logic [bus_pkg::DATA_W-1:0] ref_mem [int];
  int                         n_rows = 0;
  int                         n_errors = 0;
  bit                         table_ready = 1'b0;
  integer                     seed = 85;

  mem_subsys_top dut (.*);

  always #50 clk_i = ~clk_i;

  task automatic flag_error(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    n_errors++;
  endtask

  task automatic add_row(input bit is_wr, input bit ext, input logic [bus_pkg::ID_W-1:0] id,
                         input logic [bus_pkg::ADDR_W-1:0] addr,
                         input logic [bus_pkg::DATA_W-1:0] data,
                         input logic [bus_pkg::STRB_W-1:0] strb, input int stall);
    rows[n_rows] = '{is_wr, ext, id, addr, data, strb, stall, '0, '0, 1'b0, '0};
    n_rows++;
  endtask

  function automatic logic [bus_pkg::DATA_W-1:0] tohost_data(
      input bit done, input logic [mem_map_pkg::EXIT_CODE_W-1:0] code);
    mem_map_pkg::tohost_word_t tw;
    tw.f.done      = done;
    tw.f.exit_code = code;
    return {32'h0, tw.raw};
  endfunction

  // ----------------------------------------------------------
  // Expected responses from a reference memory
  // ----------------------------------------------------------
  task automatic predict_expected();
    mem_map_pkg::tohost_word_t                 tw;
    logic [bus_pkg::DATA_W-1:0]          word;
    logic [mem_map_pkg::EXIT_CODE_W-1:0] code;
    bit                                  exit_seen;
    int                                  w;
    exit_seen = 1'b0;
    code      = '0;
    for (int i = 0; i < n_rows; i++) begin
      w    = int'(rows[i].addr >> bus_pkg::BYTE_OFF_W);
      word = ref_mem.exists(w) ? ref_mem[w] : '0;
      rows[i].exp_resp = bus_pkg::RESP_OKAY;
      rows[i].exp_data = '0;
      if (rows[i].ext) begin
        // Responder returns the inverted address
        rows[i].exp_data = ~{32'h0, rows[i].addr};
      end else if ((rows[i].addr >> bus_pkg::BYTE_OFF_W) >= mem_map_pkg::NUM_WORDS) begin
        rows[i].exp_resp = bus_pkg::RESP_SLVERR;
      end else if (!rows[i].is_wr) begin
        rows[i].exp_data = word;
      end else begin
        for (int b = 0; b < bus_pkg::STRB_W; b++) begin
          if (rows[i].strb[b]) word[8*b +: 8] = rows[i].data[8*b +: 8];
        end
        ref_mem[w] = word;
        tw.raw = rows[i].data[31:0];
        if ((rows[i].addr >> bus_pkg::BYTE_OFF_W) ==
            (mem_map_pkg::TOHOST_ADDR >> bus_pkg::BYTE_OFF_W) &&
            (&rows[i].strb[3:0]) && tw.f.done && !exit_seen) begin
          exit_seen = 1'b1;
          code      = tw.f.exit_code;
        end
      end
      rows[i].exp_exit = exit_seen;
      rows[i].exp_code = code;
    end
  endtask

  // ----------------------------------------------------------
  // Master driver for one row
  // ----------------------------------------------------------
  task automatic run_row(input int i);
    logic [bus_pkg::ID_W-1:0]   got_id;
    logic [bus_pkg::RESP_W-1:0] got_resp;
    logic [bus_pkg::DATA_W-1:0] got_data;
    bit                         wr;
    bit                         probe;
    wr    = rows[i].is_wr;
    // Internal rows under back-pressure also offer new requests
    probe = !rows[i].ext && rows[i].stall > 0;
    @(posedge clk_i);
    ext_active_i <= rows[i].ext;
    aw_valid_i   <= wr;
    w_valid_i    <= wr;
    ar_valid_i   <= !wr;
    aw_id_i      <= rows[i].id;
    ar_id_i      <= rows[i].id;
    aw_addr_i    <= rows[i].addr;
    ar_addr_i    <= rows[i].addr;
    w_data_i     <= rows[i].data;
    w_strb_i     <= rows[i].strb;
    @(negedge clk_i);
    while (wr ? !(aw_ready_o && w_ready_o) : !ar_ready_o) @(negedge clk_i);
    // External write request carries the master payload
    if (rows[i].ext && wr && (ext_aw_addr_o !== rows[i].addr ||
        ext_w_data_o !== rows[i].data || ext_w_strb_o !== rows[i].strb))
      flag_error($sformatf("row %0d external write %h/%h/%h, expected %h/%h/%h", i,
                           ext_aw_addr_o, ext_w_data_o, ext_w_strb_o,
                           rows[i].addr, rows[i].data, rows[i].strb));
    if (!rows[i].ext && {ext_aw_valid_o, ext_w_valid_o, ext_ar_valid_o} !== 3'b000)
      flag_error($sformatf("row %0d external valid raised in internal mode", i));
    @(posedge clk_i);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
    ar_valid_i <= 1'b0;
    @(negedge clk_i);
    while (wr ? !b_valid_o : !r_valid_o) @(negedge clk_i);
    got_id   = wr ? b_id_o : r_id_o;
    got_resp = wr ? b_resp_o : r_resp_o;
    got_data = r_data_o;
    for (int k = 0; k < rows[i].stall; k++) begin
      @(posedge clk_i);
      aw_valid_i <= probe;
      w_valid_i  <= probe;
      ar_valid_i <= probe;
      @(negedge clk_i);
      if (wr ? (b_valid_o !== 1'b1 || b_id_o !== got_id || b_resp_o !== got_resp)
             : (r_valid_o !== 1'b1 || r_id_o !== got_id || r_resp_o !== got_resp ||
                r_data_o !== got_data))
        flag_error($sformatf("row %0d response moved while ready was low", i));
      if (probe && (aw_ready_o || w_ready_o || ar_ready_o))
        flag_error($sformatf("row %0d request accepted with a response pending", i));
    end
    @(posedge clk_i);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
    ar_valid_i <= 1'b0;
    b_ready_i  <= wr;
    r_ready_i  <= !wr;
    @(negedge clk_i);
    @(posedge clk_i);
    b_ready_i <= 1'b0;
    r_ready_i <= 1'b0;
    if (got_id !== rows[i].id)
      flag_error($sformatf("row %0d id %h, expected %h", i, got_id, rows[i].id));
    if (got_resp !== rows[i].exp_resp)
      flag_error($sformatf("row %0d resp %h, expected %h", i, got_resp, rows[i].exp_resp));
    if (!wr && got_data !== rows[i].exp_data)
      flag_error($sformatf("row %0d data %h, expected %h", i, got_data, rows[i].exp_data));
    @(negedge clk_i);
    if (exit_valid_o !== rows[i].exp_exit ||
        (rows[i].exp_exit && exit_code_o !== rows[i].exp_code))
      flag_error($sformatf("row %0d exit %b/%0d, expected %b/%0d", i, exit_valid_o,
                           exit_code_o, rows[i].exp_exit, rows[i].exp_code));
  endtask

  // ----------------------------------------------------------
  // One external slave responder per direction
  // ----------------------------------------------------------
  initial begin : ext_write_responder
    int                       delay;
    logic [bus_pkg::ID_W-1:0] id;
    {ext_aw_ready_i, ext_w_ready_i, ext_b_valid_i, ext_b_id_i, ext_b_resp_i} = '0;
    forever begin
      @(negedge clk_i);
      if (ext_aw_valid_o && ext_w_valid_o) begin
        id    = ext_aw_id_o;
        delay = $random(seed) & 3;
        repeat (delay + 1) @(posedge clk_i);
        ext_aw_ready_i <= 1'b1;
        ext_w_ready_i  <= 1'b1;
        @(posedge clk_i);
        ext_aw_ready_i <= 1'b0;
        ext_w_ready_i  <= 1'b0;
        ext_b_valid_i  <= 1'b1;
        ext_b_id_i     <= id;
        ext_b_resp_i   <= bus_pkg::RESP_OKAY;
        @(negedge clk_i);
        while (!ext_b_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        ext_b_valid_i <= 1'b0;
      end
    end
  end

  initial begin : ext_read_responder
    int                         delay;
    logic [bus_pkg::ID_W-1:0]   id;
    logic [bus_pkg::ADDR_W-1:0] addr;
    {ext_ar_ready_i, ext_r_valid_i, ext_r_id_i, ext_r_data_i, ext_r_resp_i} = '0;
    forever begin
      @(negedge clk_i);
      if (ext_ar_valid_o) begin
        id    = ext_ar_id_o;
        addr  = ext_ar_addr_o;
        delay = $random(seed) & 3;
        repeat (delay + 1) @(posedge clk_i);
        ext_ar_ready_i <= 1'b1;
        @(posedge clk_i);
        ext_ar_ready_i <= 1'b0;
        ext_r_valid_i  <= 1'b1;
        ext_r_id_i     <= id;
        ext_r_data_i   <= ~{32'h0, addr};
        ext_r_resp_i   <= bus_pkg::RESP_OKAY;
        @(negedge clk_i);
        while (!ext_r_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        ext_r_valid_i <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    wait (table_ready);
    repeat (n_rows * CYCLES_PER_ROW + RESET_CYCLES) @(posedge clk_i);
    $display("Timeout: the test did not finish in %0d cycles, errors so far: %0d",
             n_rows * CYCLES_PER_ROW + RESET_CYCLES, n_errors);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : main
    rst_n_i      = 1'b0;
    ext_active_i = 1'b0;
    {aw_valid_i, w_valid_i, b_ready_i, ar_valid_i, r_ready_i} = '0;
    {aw_id_i, ar_id_i, aw_addr_i, ar_addr_i, w_data_i, w_strb_i} = '0;
    // Full and partial writes with readback and back-pressure
    add_row(1'b1, 1'b0, 4'h1, 32'h0000_0100, 64'h1122_3344_5566_7788, 8'hFF, 0);
    add_row(1'b0, 1'b0, 4'h2, 32'h0000_0100, '0, '0, 0);
    add_row(1'b1, 1'b0, 4'h3, 32'h0000_0100, 64'hAAAA_BBBB_CCCC_DDDD, 8'h0F, 3);
    add_row(1'b0, 1'b0, 4'h4, 32'h0000_0100, '0, '0, 4);
    add_row(1'b1, 1'b0, 4'h5, 32'h0000_0108, 64'h0123_4567_89AB_CDEF, 8'hA5, 0);
    add_row(1'b0, 1'b0, 4'h6, 32'h0000_0108, '0, '0, 1);
    // 0x2000 would alias word 0 without the range check
    add_row(1'b1, 1'b0, 4'h7, 32'h0000_0000, 64'h5A5A_5A5A_A5A5_A5A5, 8'hFF, 0);
    add_row(1'b1, 1'b0, 4'h8, 32'h0000_2000, 64'hDEAD_BEEF_DEAD_BEEF, 8'hFF, 2);
    add_row(1'b0, 1'b0, 4'h9, 32'h0000_2000, '0, '0, 0);
    add_row(1'b0, 1'b0, 4'hA, 32'h0000_0000, '0, '0, 0);
    add_row(1'b0, 1'b0, 4'hB, 32'hFFFF_FFF8, '0, '0, 0);
    // External slave rows followed by an internal readback
    add_row(1'b1, 1'b1, 4'hC, 32'h0000_0100, 64'hFFFF_0000_FFFF_0000, 8'hFF, 2);
    add_row(1'b0, 1'b1, 4'hD, 32'h0000_0100, '0, '0, 3);
    add_row(1'b0, 1'b1, 4'hE, 32'h0000_4000, '0, '0, 0);
    add_row(1'b0, 1'b0, 4'hF, 32'h0000_0100, '0, '0, 0);
    // Host communication
    add_row(1'b1, 1'b0, 4'h0, mem_map_pkg::TOHOST_ADDR, tohost_data(1'b0, 31'd5), 8'hFF, 0);
    add_row(1'b1, 1'b0, 4'h1, mem_map_pkg::TOHOST_ADDR, tohost_data(1'b1, 31'd42), 8'hFF, 1);
    add_row(1'b1, 1'b0, 4'h2, mem_map_pkg::TOHOST_ADDR, tohost_data(1'b1, 31'd7), 8'hFF, 0);
    add_row(1'b0, 1'b0, 4'h3, mem_map_pkg::TOHOST_ADDR, '0, '0, 0);
    predict_expected();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    if ({b_valid_o, r_valid_o, aw_ready_o, ar_ready_o, exit_valid_o,
         ext_aw_valid_o, ext_ar_valid_o} !== '0)
      flag_error("outputs not idle after reset");
    for (int i = 0; i < n_rows; i++) run_row(i);
    $display("rows run: %0d, errors: %0d", n_rows, n_errors);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_mem_subsys -o tb_mem_subsys

out=$(./obj_dir/tb_mem_subsys)
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
  exit 0
fi
echo "simulation did not pass"
exit 1

// ==== sources.f ====
verilog/bus_pkg.sv
verilog/mem_map_pkg.sv
verilog/bus_switch.sv
verilog/bus_to_mem.sv
verilog/sram_model.sv
verilog/tohost_monitor.sv
verilog/mem_subsys_top.sv
dv/tb_mem_subsys.sv

// ==== verilog/bus_pkg.sv ====
// Bus package
// Widths and response codes of the single-beat read/write bus

package bus_pkg;

  // ----------------------------------------------------------
  // Channel widths
  // ----------------------------------------------------------
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 64;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned ID_W   = 4;

  // Low address bits that pick a byte inside one data word
  localparam int unsigned BYTE_OFF_W = $clog2(STRB_W);

  // ----------------------------------------------------------
  // Response codes
  // ----------------------------------------------------------
  localparam int unsigned RESP_W = 2;

  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== verilog/bus_switch.sv ====
// Bus switch
// Steers master traffic to the memory bridge or to the external slave port

`timescale 1ns/1ps

module bus_switch (
  input  logic                           ext_active_i,
  // Master side requests
  input  logic                           m_aw_valid_i, m_w_valid_i, m_b_ready_i,
  input  logic                           m_ar_valid_i, m_r_ready_i,
  input  logic [bus_pkg::ID_W-1:0]       m_aw_id_i, m_ar_id_i,
  input  logic [bus_pkg::ADDR_W-1:0]     m_aw_addr_i, m_ar_addr_i,
  input  logic [bus_pkg::DATA_W-1:0]     m_w_data_i,
  input  logic [bus_pkg::STRB_W-1:0]     m_w_strb_i,
  // Bridge responses
  input  logic                           s_aw_ready_i, s_w_ready_i, s_b_valid_i,
  input  logic                           s_ar_ready_i, s_r_valid_i,
  input  logic [bus_pkg::ID_W-1:0]       s_b_id_i, s_r_id_i,
  input  logic [bus_pkg::RESP_W-1:0]     s_b_resp_i, s_r_resp_i,
  input  logic [bus_pkg::DATA_W-1:0]     s_r_data_i,
  // External slave responses
  input  logic                           ext_aw_ready_i, ext_w_ready_i, ext_b_valid_i,
  input  logic                           ext_ar_ready_i, ext_r_valid_i,
  input  logic [bus_pkg::ID_W-1:0]       ext_b_id_i, ext_r_id_i,
  input  logic [bus_pkg::RESP_W-1:0]     ext_b_resp_i, ext_r_resp_i,
  input  logic [bus_pkg::DATA_W-1:0]     ext_r_data_i,
  // Master side responses
  output logic                           m_aw_ready_o, m_w_ready_o, m_b_valid_o,
  output logic                           m_ar_ready_o, m_r_valid_o,
  output logic [bus_pkg::ID_W-1:0]       m_b_id_o, m_r_id_o,
  output logic [bus_pkg::RESP_W-1:0]     m_b_resp_o, m_r_resp_o,
  output logic [bus_pkg::DATA_W-1:0]     m_r_data_o,
  // Bridge requests
  output logic                           s_aw_valid_o, s_w_valid_o, s_b_ready_o,
  output logic                           s_ar_valid_o, s_r_ready_o,
  output logic [bus_pkg::ID_W-1:0]       s_aw_id_o, s_ar_id_o,
  output logic [bus_pkg::ADDR_W-1:0]     s_aw_addr_o, s_ar_addr_o,
  output logic [bus_pkg::DATA_W-1:0]     s_w_data_o,
  output logic [bus_pkg::STRB_W-1:0]     s_w_strb_o,
  // External slave requests
  output logic                           ext_aw_valid_o, ext_w_valid_o, ext_b_ready_o,
  output logic                           ext_ar_valid_o, ext_r_ready_o,
  output logic [bus_pkg::ID_W-1:0]       ext_aw_id_o, ext_ar_id_o,
  output logic [bus_pkg::ADDR_W-1:0]     ext_aw_addr_o, ext_ar_addr_o,
  output logic [bus_pkg::DATA_W-1:0]     ext_w_data_o,
  output logic [bus_pkg::STRB_W-1:0]     ext_w_strb_o
);

  // ----------------------------------------------------------
  // Response path back to the master
  // ----------------------------------------------------------
  assign {m_aw_ready_o, m_w_ready_o, m_b_valid_o, m_b_id_o, m_b_resp_o,
          m_ar_ready_o, m_r_valid_o, m_r_id_o, m_r_data_o, m_r_resp_o} =
    ext_active_i ?
      {ext_aw_ready_i, ext_w_ready_i, ext_b_valid_i, ext_b_id_i, ext_b_resp_i,
       ext_ar_ready_i, ext_r_valid_i, ext_r_id_i, ext_r_data_i, ext_r_resp_i} :
      {s_aw_ready_i, s_w_ready_i, s_b_valid_i, s_b_id_i, s_b_resp_i,
       s_ar_ready_i, s_r_valid_i, s_r_id_i, s_r_data_i, s_r_resp_i};

  // ----------------------------------------------------------
  // Handshakes reach only the selected target
  // ----------------------------------------------------------
  assign s_aw_valid_o = m_aw_valid_i & ~ext_active_i;
  assign s_w_valid_o  = m_w_valid_i  & ~ext_active_i;
  assign s_b_ready_o  = m_b_ready_i  & ~ext_active_i;
  assign s_ar_valid_o = m_ar_valid_i & ~ext_active_i;
  assign s_r_ready_o  = m_r_ready_i  & ~ext_active_i;

  assign ext_aw_valid_o = m_aw_valid_i & ext_active_i;
  assign ext_w_valid_o  = m_w_valid_i  & ext_active_i;
  assign ext_b_ready_o  = m_b_ready_i  & ext_active_i;
  assign ext_ar_valid_o = m_ar_valid_i & ext_active_i;
  assign ext_r_ready_o  = m_r_ready_i  & ext_active_i;

  // Payload goes to both sides
  assign {s_aw_id_o, s_aw_addr_o, s_w_data_o, s_w_strb_o, s_ar_id_o, s_ar_addr_o} =
    {m_aw_id_i, m_aw_addr_i, m_w_data_i, m_w_strb_i, m_ar_id_i, m_ar_addr_i};
  assign {ext_aw_id_o, ext_aw_addr_o, ext_w_data_o, ext_w_strb_o, ext_ar_id_o, ext_ar_addr_o} =
    {m_aw_id_i, m_aw_addr_i, m_w_data_i, m_w_strb_i, m_ar_id_i, m_ar_addr_i};

endmodule

// ==== verilog/bus_to_mem.sv ====
// Bus to memory bridge
// Serves one single-beat read or write at a time as an SRAM request

`timescale 1ns/1ps

module bus_to_mem (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Write address, data and response
  input  logic                                aw_valid_i,
  input  logic [bus_pkg::ID_W-1:0]            aw_id_i,
  input  logic [bus_pkg::ADDR_W-1:0]          aw_addr_i,
  output logic                                aw_ready_o,
  input  logic                                w_valid_i,
  input  logic [bus_pkg::DATA_W-1:0]          w_data_i,
  input  logic [bus_pkg::STRB_W-1:0]          w_strb_i,
  output logic                                w_ready_o,
  output logic                                b_valid_o,
  output logic [bus_pkg::ID_W-1:0]            b_id_o,
  output logic [bus_pkg::RESP_W-1:0]          b_resp_o,
  input  logic                                b_ready_i,
  // Read address and data
  input  logic                                ar_valid_i,
  input  logic [bus_pkg::ID_W-1:0]            ar_id_i,
  input  logic [bus_pkg::ADDR_W-1:0]          ar_addr_i,
  output logic                                ar_ready_o,
  output logic                                r_valid_o,
  output logic [bus_pkg::ID_W-1:0]            r_id_o,
  output logic [bus_pkg::DATA_W-1:0]          r_data_o,
  output logic [bus_pkg::RESP_W-1:0]          r_resp_o,
  input  logic                                r_ready_i,
  // SRAM port
  output logic                                mem_req_o,
  output logic                                mem_we_o,
  output logic [mem_map_pkg::WORD_ADDR_W-1:0] mem_addr_o,
  output logic [bus_pkg::STRB_W-1:0]          mem_be_o,
  output logic [bus_pkg::DATA_W-1:0]          mem_wdata_o,
  input  logic [bus_pkg::DATA_W-1:0]          mem_rdata_i
);

  // Controller state is idle, write response or read response.
  // The two pending flags are never high together.
  logic                       b_pend_q;
  logic                       r_pend_q;
  logic [bus_pkg::ID_W-1:0]   id_q;
  logic [bus_pkg::RESP_W-1:0] resp_q;
  logic                       rd_err_q;

  logic idle;
  logic wr_both;
  logic wr_go;
  logic rd_go;
  logic wr_ok;
  logic rd_ok;

  assign idle    = ~b_pend_q & ~r_pend_q;
  assign wr_both = aw_valid_i & w_valid_i;

  // Write wins when both directions ask in the same cycle
  assign wr_go = idle & wr_both;
  assign rd_go = idle & ar_valid_i & ~wr_both;

  // Range check on the word index
  assign wr_ok = (aw_addr_i >> bus_pkg::BYTE_OFF_W) < mem_map_pkg::NUM_WORDS;
  assign rd_ok = (ar_addr_i >> bus_pkg::BYTE_OFF_W) < mem_map_pkg::NUM_WORDS;

  assign aw_ready_o = wr_go;
  assign w_ready_o  = wr_go;
  assign ar_ready_o = rd_go;

  // ----------------------------------------------------------
  // SRAM request, issued in the accept cycle
  // ----------------------------------------------------------
  assign mem_req_o   = (wr_go & wr_ok & (|w_strb_i)) | (rd_go & rd_ok);
  assign mem_we_o    = wr_go;
  assign mem_addr_o  = wr_go ? aw_addr_i[bus_pkg::BYTE_OFF_W +: mem_map_pkg::WORD_ADDR_W]
                             : ar_addr_i[bus_pkg::BYTE_OFF_W +: mem_map_pkg::WORD_ADDR_W];
  assign mem_be_o    = w_strb_i;
  assign mem_wdata_o = w_data_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_pend_q <= 1'b0;
      r_pend_q <= 1'b0;
    end else begin
      if (wr_go) begin
        b_pend_q <= 1'b1;
      end else if (b_pend_q && b_ready_i) begin
        b_pend_q <= 1'b0;
      end
      if (rd_go) begin
        r_pend_q <= 1'b1;
      end else if (r_pend_q && r_ready_i) begin
        r_pend_q <= 1'b0;
      end
    end
  end

  // Response fields held until the master takes them
  always_ff @(posedge clk_i) begin
    if (wr_go) begin
      id_q   <= aw_id_i;
      resp_q <= wr_ok ? bus_pkg::RESP_OKAY : bus_pkg::RESP_SLVERR;
    end else if (rd_go) begin
      id_q     <= ar_id_i;
      resp_q   <= rd_ok ? bus_pkg::RESP_OKAY : bus_pkg::RESP_SLVERR;
      rd_err_q <= ~rd_ok;
    end
  end

  // ----------------------------------------------------------
  // Response channels
  // ----------------------------------------------------------
  assign b_valid_o = b_pend_q;
  assign b_id_o    = id_q;
  assign b_resp_o  = resp_q;

  // SRAM output stays put while the read response waits
  assign r_valid_o = r_pend_q;
  assign r_id_o    = id_q;
  assign r_resp_o  = resp_q;
  assign r_data_o  = rd_err_q ? '0 : mem_rdata_i;

endmodule

// ==== verilog/mem_map_pkg.sv ====
// Memory map package
// Internal memory size, the tohost location and the tohost word layout

package mem_map_pkg;

  // 8 KiB of 64-bit words starting at byte address 0
  localparam int unsigned NUM_WORDS   = 1024;
  localparam int unsigned WORD_ADDR_W = $clog2(NUM_WORDS);

  // ----------------------------------------------------------
  // Host communication
  // ----------------------------------------------------------
  localparam logic [bus_pkg::ADDR_W-1:0] TOHOST_ADDR = 32'h0000_1000;

  // Word index of tohost as seen on the SRAM port
  localparam logic [WORD_ADDR_W-1:0] TOHOST_WORD =
    WORD_ADDR_W'(TOHOST_ADDR >> bus_pkg::BYTE_OFF_W);

  localparam int unsigned EXIT_CODE_W = 31;

  // Field view of the low tohost word
  typedef struct packed {
    logic [EXIT_CODE_W-1:0] exit_code;
    logic                   done;
  } tohost_fields_t;

  // Same 32 bits seen as raw store data or as fields
  typedef union packed {
    logic [31:0]    raw;
    tohost_fields_t f;
  } tohost_word_t;

endpackage

// ==== verilog/mem_subsys_top.sv ====
// Memory subsystem top
// Bus switch, memory bridge, SRAM and tohost monitor

`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                ext_active_i,
  // Master port
  input  logic                                aw_valid_i, w_valid_i, b_ready_i,
  input  logic                                ar_valid_i, r_ready_i,
  input  logic [bus_pkg::ID_W-1:0]            aw_id_i, ar_id_i,
  input  logic [bus_pkg::ADDR_W-1:0]          aw_addr_i, ar_addr_i,
  input  logic [bus_pkg::DATA_W-1:0]          w_data_i,
  input  logic [bus_pkg::STRB_W-1:0]          w_strb_i,
  output logic                                aw_ready_o, w_ready_o, b_valid_o,
  output logic                                ar_ready_o, r_valid_o,
  output logic [bus_pkg::ID_W-1:0]            b_id_o, r_id_o,
  output logic [bus_pkg::RESP_W-1:0]          b_resp_o, r_resp_o,
  output logic [bus_pkg::DATA_W-1:0]          r_data_o,
  // External slave port
  output logic                                ext_aw_valid_o, ext_w_valid_o, ext_b_ready_o,
  output logic                                ext_ar_valid_o, ext_r_ready_o,
  output logic [bus_pkg::ID_W-1:0]            ext_aw_id_o, ext_ar_id_o,
  output logic [bus_pkg::ADDR_W-1:0]          ext_aw_addr_o, ext_ar_addr_o,
  output logic [bus_pkg::DATA_W-1:0]          ext_w_data_o,
  output logic [bus_pkg::STRB_W-1:0]          ext_w_strb_o,
  input  logic                                ext_aw_ready_i, ext_w_ready_i, ext_b_valid_i,
  input  logic                                ext_ar_ready_i, ext_r_valid_i,
  input  logic [bus_pkg::ID_W-1:0]            ext_b_id_i, ext_r_id_i,
  input  logic [bus_pkg::RESP_W-1:0]          ext_b_resp_i, ext_r_resp_i,
  input  logic [bus_pkg::DATA_W-1:0]          ext_r_data_i,
  // End of test
  output logic                                exit_valid_o,
  output logic [mem_map_pkg::EXIT_CODE_W-1:0] exit_code_o
);

  // Switch to bridge
  logic                                s_aw_valid, s_w_valid, s_b_ready, s_ar_valid, s_r_ready;
  logic                                s_aw_ready, s_w_ready, s_b_valid, s_ar_ready, s_r_valid;
  logic [bus_pkg::ID_W-1:0]            s_aw_id, s_ar_id, s_b_id, s_r_id;
  logic [bus_pkg::ADDR_W-1:0]          s_aw_addr, s_ar_addr;
  logic [bus_pkg::DATA_W-1:0]          s_w_data, s_r_data;
  logic [bus_pkg::STRB_W-1:0]          s_w_strb;
  logic [bus_pkg::RESP_W-1:0]          s_b_resp, s_r_resp;

  // Bridge to SRAM
  logic                                mem_req;
  logic                                mem_we;
  logic [mem_map_pkg::WORD_ADDR_W-1:0] mem_addr;
  logic [bus_pkg::STRB_W-1:0]          mem_be;
  logic [bus_pkg::DATA_W-1:0]          mem_wdata;
  logic [bus_pkg::DATA_W-1:0]          mem_rdata;

  // ----------------------------------------------------------
  // Routing
  // ----------------------------------------------------------
  bus_switch u_switch (
    .ext_active_i   (ext_active_i),
    .m_aw_valid_i   (aw_valid_i),     .m_w_valid_i  (w_valid_i),   .m_b_ready_i (b_ready_i),
    .m_ar_valid_i   (ar_valid_i),     .m_r_ready_i  (r_ready_i),
    .m_aw_id_i      (aw_id_i),        .m_ar_id_i    (ar_id_i),
    .m_aw_addr_i    (aw_addr_i),      .m_ar_addr_i  (ar_addr_i),
    .m_w_data_i     (w_data_i),       .m_w_strb_i   (w_strb_i),
    .s_aw_ready_i   (s_aw_ready),     .s_w_ready_i  (s_w_ready),   .s_b_valid_i (s_b_valid),
    .s_ar_ready_i   (s_ar_ready),     .s_r_valid_i  (s_r_valid),
    .s_b_id_i       (s_b_id),         .s_r_id_i     (s_r_id),
    .s_b_resp_i     (s_b_resp),       .s_r_resp_i   (s_r_resp),    .s_r_data_i  (s_r_data),
    .ext_aw_ready_i (ext_aw_ready_i), .ext_w_ready_i(ext_w_ready_i),
    .ext_b_valid_i  (ext_b_valid_i),  .ext_ar_ready_i(ext_ar_ready_i),
    .ext_r_valid_i  (ext_r_valid_i),  .ext_b_id_i   (ext_b_id_i),  .ext_r_id_i  (ext_r_id_i),
    .ext_b_resp_i   (ext_b_resp_i),   .ext_r_resp_i (ext_r_resp_i),
    .ext_r_data_i   (ext_r_data_i),
    .m_aw_ready_o   (aw_ready_o),     .m_w_ready_o  (w_ready_o),   .m_b_valid_o (b_valid_o),
    .m_ar_ready_o   (ar_ready_o),     .m_r_valid_o  (r_valid_o),
    .m_b_id_o       (b_id_o),         .m_r_id_o     (r_id_o),
    .m_b_resp_o     (b_resp_o),       .m_r_resp_o   (r_resp_o),    .m_r_data_o  (r_data_o),
    .s_aw_valid_o   (s_aw_valid),     .s_w_valid_o  (s_w_valid),   .s_b_ready_o (s_b_ready),
    .s_ar_valid_o   (s_ar_valid),     .s_r_ready_o  (s_r_ready),
    .s_aw_id_o      (s_aw_id),        .s_ar_id_o    (s_ar_id),
    .s_aw_addr_o    (s_aw_addr),      .s_ar_addr_o  (s_ar_addr),
    .s_w_data_o     (s_w_data),       .s_w_strb_o   (s_w_strb),
    .ext_aw_valid_o (ext_aw_valid_o), .ext_w_valid_o(ext_w_valid_o),
    .ext_b_ready_o  (ext_b_ready_o),  .ext_ar_valid_o(ext_ar_valid_o),
    .ext_r_ready_o  (ext_r_ready_o),  .ext_aw_id_o  (ext_aw_id_o), .ext_ar_id_o (ext_ar_id_o),
    .ext_aw_addr_o  (ext_aw_addr_o),  .ext_ar_addr_o(ext_ar_addr_o),
    .ext_w_data_o   (ext_w_data_o),   .ext_w_strb_o (ext_w_strb_o)
  );

  // ----------------------------------------------------------
  // Internal memory
  // ----------------------------------------------------------
  bus_to_mem u_bridge (
    .clk_i      (clk_i),      .rst_n_i    (rst_n_i),
    .aw_valid_i (s_aw_valid), .aw_id_i    (s_aw_id),   .aw_addr_i (s_aw_addr),
    .aw_ready_o (s_aw_ready),
    .w_valid_i  (s_w_valid),  .w_data_i   (s_w_data),  .w_strb_i  (s_w_strb),
    .w_ready_o  (s_w_ready),
    .b_valid_o  (s_b_valid),  .b_id_o     (s_b_id),    .b_resp_o  (s_b_resp),
    .b_ready_i  (s_b_ready),
    .ar_valid_i (s_ar_valid), .ar_id_i    (s_ar_id),   .ar_addr_i (s_ar_addr),
    .ar_ready_o (s_ar_ready),
    .r_valid_o  (s_r_valid),  .r_id_o     (s_r_id),    .r_data_o  (s_r_data),
    .r_resp_o   (s_r_resp),   .r_ready_i  (s_r_ready),
    .mem_req_o  (mem_req),    .mem_we_o   (mem_we),    .mem_addr_o(mem_addr),
    .mem_be_o   (mem_be),     .mem_wdata_o(mem_wdata), .mem_rdata_i(mem_rdata)
  );

  sram_model u_sram (
    .clk_i      (clk_i),
    .mem_req_i  (mem_req),    .mem_we_i   (mem_we),    .mem_addr_i(mem_addr),
    .mem_be_i   (mem_be),     .mem_wdata_i(mem_wdata), .mem_rdata_o(mem_rdata)
  );

  // Watches the same SRAM port for the tohost store
  tohost_monitor u_tohost (
    .clk_i       (clk_i),     .rst_n_i    (rst_n_i),
    .mem_req_i   (mem_req),   .mem_we_i   (mem_we),    .mem_addr_i(mem_addr),
    .mem_be_i    (mem_be),    .mem_wdata_i(mem_wdata),
    .exit_valid_o(exit_valid_o),
    .exit_code_o (exit_code_o)
  );

endmodule

// ==== verilog/sram_model.sv ====
// SRAM model
// Word memory with byte enables and a registered one-cycle read

`timescale 1ns/1ps

module sram_model (
  input  logic                                clk_i,
  input  logic                                mem_req_i,
  input  logic                                mem_we_i,
  input  logic [mem_map_pkg::WORD_ADDR_W-1:0] mem_addr_i,
  input  logic [bus_pkg::STRB_W-1:0]          mem_be_i,
  input  logic [bus_pkg::DATA_W-1:0]          mem_wdata_i,
  output logic [bus_pkg::DATA_W-1:0]          mem_rdata_o
);

  // Starts out all zero
  logic [bus_pkg::DATA_W-1:0] mem_q [mem_map_pkg::NUM_WORDS] = '{default: '0};

  always_ff @(posedge clk_i) begin
    if (mem_req_i) begin
      if (mem_we_i) begin
        // Only strobed bytes change
        for (int b = 0; b < bus_pkg::STRB_W; b++) begin
          if (mem_be_i[b]) begin
            mem_q[mem_addr_i][8*b +: 8] <= mem_wdata_i[8*b +: 8];
          end
        end
      end else begin
        mem_rdata_o <= mem_q[mem_addr_i];
      end
    end
  end

endmodule

// ==== verilog/tohost_monitor.sv ====
// Tohost monitor
// Catches the end-of-test store to tohost and keeps its exit code

`timescale 1ns/1ps

module tohost_monitor (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                mem_req_i,
  input  logic                                mem_we_i,
  input  logic [mem_map_pkg::WORD_ADDR_W-1:0] mem_addr_i,
  input  logic [bus_pkg::STRB_W-1:0]          mem_be_i,
  input  logic [bus_pkg::DATA_W-1:0]          mem_wdata_i,
  output logic                                exit_valid_o,
  output logic [mem_map_pkg::EXIT_CODE_W-1:0] exit_code_o
);

  mem_map_pkg::tohost_word_t word;
  logic                      hit;

  assign word.raw = mem_wdata_i[31:0];

  // Full store to the low 32 bits of the tohost word
  assign hit = mem_req_i & mem_we_i & (&mem_be_i[3:0])
             & (mem_addr_i == mem_map_pkg::TOHOST_WORD);

  // First store with done set wins
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_o <= 1'b0;
      exit_code_o  <= '0;
    end else if (hit && word.f.done && !exit_valid_o) begin
      exit_valid_o <= 1'b1;
      exit_code_o  <= word.f.exit_code;
    end
  end

endmodule
